// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  localparam int unsigned RegAddrWidth = 5;

  // major opcodes in instr[6:0]
  typedef enum logic [6:0] {
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // funct3 for SYSTEM
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;

  // funct7 of the register-register ops
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef enum logic [11:0] {
    CSR_MSCRATCH = 12'h340,
    CSR_MINSTRET = 12'hB02
  } csr_addr_e;

  localparam logic [3:0] CauseIllegalInstr = 4'd2;

endpackage

`default_nettype wire

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // operation carried from decode to the ALU
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_LUI,
    OP_CSRRW,
    OP_CSRRS
  } fu_op_e;

  // source of operand b
  typedef enum logic {
    OPB_REG,
    OPB_IMM
  } opb_sel_e;

endpackage

`default_nettype wire

// ==== src/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage import riscv_pkg::*; import core_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_valid_i,
  input  logic [31:0]             fetch_instr_i,
  input  logic [Xlen-1:0]         fetch_pc_i,
  output logic                    fetch_ready_o,
  input  logic                    stall_i,
  output logic                    valid_o,
  output logic [Xlen-1:0]         pc_o,
  output fu_op_e                  op_o,
  output opb_sel_e                opb_sel_o,
  output logic [RegAddrWidth-1:0] rs1_o,
  output logic [RegAddrWidth-1:0] rs2_o,
  output logic [RegAddrWidth-1:0] rd_o,
  output logic [Xlen-1:0]         imm_o,
  output logic [11:0]             csr_addr_o,
  output logic                    we_o,
  output logic                    illegal_o
);

  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [11:0]             csr_addr;
  logic [RegAddrWidth-1:0] rd;
  fu_op_e                  op_d;
  opb_sel_e                opb_sel_d;
  logic [Xlen-1:0]         imm_d;
  logic                    illegal_d;

  assign funct3   = fetch_instr_i[14:12];
  assign funct7   = fetch_instr_i[31:25];
  assign csr_addr = fetch_instr_i[31:20];
  assign rd       = fetch_instr_i[11:7];

  // the whole pipeline moves together, so decode is ready unless stalled
  assign fetch_ready_o = ~stall_i;

  // ----------------------------------------------------------------------
  // decoder
  // ----------------------------------------------------------------------
  always_comb begin
    op_d      = OP_ADD;
    opb_sel_d = OPB_REG;
    imm_d     = Xlen'($signed(fetch_instr_i[31:20]));
    illegal_d = 1'b0;
    case (fetch_instr_i[6:0])
      OPCODE_LUI: begin
        op_d      = OP_LUI;
        opb_sel_d = OPB_IMM;
        imm_d     = Xlen'($signed({fetch_instr_i[31:12], 12'b0}));
      end
      OPCODE_OP_IMM: begin
        opb_sel_d = OPB_IMM;
        case (funct3)
          F3_ADD_SUB: op_d = OP_ADD;
          F3_AND:     op_d = OP_AND;
          F3_OR:      op_d = OP_OR;
          F3_XOR:     op_d = OP_XOR;
          default:    illegal_d = 1'b1;
        endcase
      end
      OPCODE_OP: begin
        case (funct3)
          F3_ADD_SUB: op_d = (funct7 == F7_SUB) ? OP_SUB : OP_ADD;
          F3_AND:     op_d = OP_AND;
          F3_OR:      op_d = OP_OR;
          F3_XOR:     op_d = OP_XOR;
          F3_SLL:     op_d = OP_SLL;
          F3_SRL:     op_d = OP_SRL;
          default:    illegal_d = 1'b1;
        endcase
        // only sub uses a non-zero funct7 here, sra and mul* are not supported
        if (funct7 != F7_BASE && !(funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
          illegal_d = 1'b1;
        end
      end
      OPCODE_SYSTEM: begin
        case (funct3)
          F3_CSRRW: op_d = OP_CSRRW;
          F3_CSRRS: op_d = OP_CSRRS;
          default:  illegal_d = 1'b1;
        endcase
        if (csr_addr != CSR_MSCRATCH && csr_addr != CSR_MINSTRET) begin
          illegal_d = 1'b1;
        end
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_o       <= fetch_pc_i;
      op_o       <= op_d;
      opb_sel_o  <= opb_sel_d;
      rs1_o      <= fetch_instr_i[19:15];
      rs2_o      <= fetch_instr_i[24:20];
      rd_o       <= rd;
      imm_o      <= imm_d;
      csr_addr_o <= csr_addr;
      // x0 is never written
      we_o       <= ~illegal_d & (rd != '0);
      illegal_o  <= illegal_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage import riscv_pkg::*; import core_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    stall_i,
  input  logic                    valid_i,
  input  logic [Xlen-1:0]         pc_i,
  input  fu_op_e                  op_i,
  input  opb_sel_e                opb_sel_i,
  input  logic [RegAddrWidth-1:0] rs1_i,
  input  logic [RegAddrWidth-1:0] rs2_i,
  input  logic [RegAddrWidth-1:0] rd_i,
  input  logic [Xlen-1:0]         imm_i,
  input  logic [11:0]             csr_addr_i,
  input  logic                    we_i,
  input  logic                    illegal_i,
  // write port, driven from ex
  input  logic                    wb_we_i,
  input  logic [RegAddrWidth-1:0] wb_rd_i,
  input  logic [Xlen-1:0]         wb_data_i,
  output logic                    valid_o,
  output logic [Xlen-1:0]         pc_o,
  output fu_op_e                  op_o,
  output logic [Xlen-1:0]         opa_o,
  output logic [Xlen-1:0]         opb_o,
  output logic [RegAddrWidth-1:0] rd_o,
  output logic [11:0]             csr_addr_o,
  output logic                    we_o,
  output logic                    illegal_o
);

  logic [Xlen-1:0] rf_q [32];
  logic [Xlen-1:0] rs1_val;
  logic [Xlen-1:0] rs2_val;

  always_ff @(posedge clk_i) begin
    if (wb_we_i && wb_rd_i != '0) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  // x0 reads zero, then the result leaving ex beats the array
  assign rs1_val = (rs1_i == '0) ? '0 :
                   (wb_we_i && wb_rd_i == rs1_i) ? wb_data_i : rf_q[rs1_i];
  assign rs2_val = (rs2_i == '0) ? '0 :
                   (wb_we_i && wb_rd_i == rs2_i) ? wb_data_i : rf_q[rs2_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_o       <= pc_i;
      op_o       <= op_i;
      opa_o      <= rs1_val;
      opb_o      <= (opb_sel_i == OPB_IMM) ? imm_i : rs2_val;
      rd_o       <= rd_i;
      csr_addr_o <= csr_addr_i;
      we_o       <= we_i;
      illegal_o  <= illegal_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage import riscv_pkg::*; import core_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic                    stall_i,
  input  logic                    valid_i,
  input  logic [Xlen-1:0]         pc_i,
  input  fu_op_e                  op_i,
  input  logic [Xlen-1:0]         opa_i,
  input  logic [Xlen-1:0]         opb_i,
  input  logic [RegAddrWidth-1:0] rd_i,
  input  logic [11:0]             csr_addr_i,
  input  logic                    we_i,
  input  logic                    illegal_i,
  input  logic [Xlen-1:0]         csr_rdata_i,
  output logic                    csr_we_o,
  output logic [11:0]             csr_addr_o,
  output logic [Xlen-1:0]         csr_wdata_o,
  output logic                    retire_o,
  output logic                    wb_we_o,
  output logic [RegAddrWidth-1:0] wb_rd_o,
  output logic [Xlen-1:0]         wb_data_o,
  output logic                    valid_o,
  output logic [Xlen-1:0]         pc_o,
  output logic                    illegal_o
);

  localparam int unsigned ShamtWidth = $clog2(Xlen);

  logic advance;
  logic is_csr;

  // instruction moves into the commit register on this edge
  assign advance = valid_i & ~stall_i;
  assign is_csr  = (op_i == OP_CSRRW) || (op_i == OP_CSRRS);

  always_comb begin
    case (op_i)
      OP_ADD:   wb_data_o = opa_i + opb_i;
      OP_SUB:   wb_data_o = opa_i - opb_i;
      OP_AND:   wb_data_o = opa_i & opb_i;
      OP_OR:    wb_data_o = opa_i | opb_i;
      OP_XOR:   wb_data_o = opa_i ^ opb_i;
      OP_SLL:   wb_data_o = opa_i << opb_i[ShamtWidth-1:0];
      OP_SRL:   wb_data_o = opa_i >> opb_i[ShamtWidth-1:0];
      OP_LUI:   wb_data_o = opb_i;
      // csr ops return the old value
      OP_CSRRW: wb_data_o = csr_rdata_i;
      OP_CSRRS: wb_data_o = csr_rdata_i;
      default:  wb_data_o = '0;
    endcase
  end

  assign csr_addr_o  = csr_addr_i;
  assign csr_wdata_o = (op_i == OP_CSRRS) ? (csr_rdata_i | opa_i) : opa_i;
  assign csr_we_o    = advance & is_csr & ~illegal_i;
  assign retire_o    = advance & ~illegal_i;

  assign wb_we_o = advance & we_i;
  assign wb_rd_o = rd_i;

  assign valid_o   = valid_i;
  assign pc_o      = pc_i;
  assign illegal_o = illegal_i;

endmodule

`default_nettype wire

// ==== src/csr_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_regfile import riscv_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [11:0]     csr_addr_i,
  input  logic            csr_we_i,
  input  logic [Xlen-1:0] csr_wdata_i,
  input  logic            retire_i,
  output logic [Xlen-1:0] csr_rdata_o
);

  logic [Xlen-1:0] mscratch_q;
  logic [Xlen-1:0] minstret_q;

  always_comb begin
    case (csr_addr_i)
      CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      CSR_MINSTRET: csr_rdata_o = minstret_q;
      default:      csr_rdata_o = '0;
    endcase
  end

  // minstret only counts, writes to it are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mscratch_q <= '0;
      minstret_q <= '0;
    end else begin
      if (csr_we_i && csr_addr_i == CSR_MSCRATCH) begin
        mscratch_q <= csr_wdata_i;
      end
      if (retire_i) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/commit_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_stage import riscv_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_i,
  input  logic [Xlen-1:0]         pc_i,
  input  logic [RegAddrWidth-1:0] rd_i,
  input  logic [Xlen-1:0]         wdata_i,
  input  logic                    we_i,
  input  logic                    illegal_i,
  input  logic                    commit_ready_i,
  output logic                    stall_o,
  output logic                    commit_valid_o,
  output logic [Xlen-1:0]         commit_pc_o,
  output logic [RegAddrWidth-1:0] commit_rd_o,
  output logic [Xlen-1:0]         commit_wdata_o,
  output logic                    commit_we_o,
  output logic                    commit_exception_o,
  output logic [3:0]              commit_cause_o
);

  // trace consumer holding off freezes the whole pipeline
  assign stall_o = commit_valid_o & ~commit_ready_i;

  assign commit_cause_o = commit_exception_o ? CauseIllegalInstr : 4'd0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o <= 1'b0;
    end else if (!stall_o) begin
      commit_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      commit_pc_o        <= pc_i;
      commit_rd_o        <= rd_i;
      commit_wdata_o     <= wdata_i;
      commit_we_o        <= we_i;
      commit_exception_o <= illegal_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_mini_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_mini_core import riscv_pkg::*; import core_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // fetch port
  input  logic                    fetch_valid_i,
  input  logic [31:0]             fetch_instr_i,
  input  logic [Xlen-1:0]         fetch_pc_i,
  output logic                    fetch_ready_o,
  // commit trace port
  input  logic                    commit_ready_i,
  output logic                    commit_valid_o,
  output logic [Xlen-1:0]         commit_pc_o,
  output logic [RegAddrWidth-1:0] commit_rd_o,
  output logic [Xlen-1:0]         commit_wdata_o,
  output logic                    commit_we_o,
  output logic                    commit_exception_o,
  output logic [3:0]              commit_cause_o
);

  // ----------------------------------------------------------------------
  // stage to stage wires
  // ----------------------------------------------------------------------
  logic                    stall;

  // id -> issue
  logic                    valid_id, we_id, illegal_id;
  logic [Xlen-1:0]         pc_id, imm_id;
  fu_op_e                  op_id;
  opb_sel_e                opb_sel_id;
  logic [RegAddrWidth-1:0] rs1_id, rs2_id, rd_id;
  logic [11:0]             csr_addr_id;

  // issue -> ex
  logic                    valid_is, we_is, illegal_is;
  logic [Xlen-1:0]         pc_is, opa_is, opb_is;
  fu_op_e                  op_is;
  logic [RegAddrWidth-1:0] rd_is;
  logic [11:0]             csr_addr_is;

  // ex -> register file, csr file and commit
  logic                    valid_ex, illegal_ex, wb_we_ex, csr_we_ex, retire_ex;
  logic [Xlen-1:0]         pc_ex, wb_data_ex, csr_wdata_ex, csr_rdata;
  logic [RegAddrWidth-1:0] wb_rd_ex;
  logic [11:0]             csr_addr_ex;

  id_stage #(
    .Xlen ( Xlen )
  ) i_id_stage (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_instr_i,
    .fetch_pc_i,
    .fetch_ready_o,
    .stall_i    ( stall       ),
    .valid_o    ( valid_id    ),
    .pc_o       ( pc_id       ),
    .op_o       ( op_id       ),
    .opb_sel_o  ( opb_sel_id  ),
    .rs1_o      ( rs1_id      ),
    .rs2_o      ( rs2_id      ),
    .rd_o       ( rd_id       ),
    .imm_o      ( imm_id      ),
    .csr_addr_o ( csr_addr_id ),
    .we_o       ( we_id       ),
    .illegal_o  ( illegal_id  )
  );

  issue_stage #(
    .Xlen ( Xlen )
  ) i_issue_stage (
    .clk_i,
    .rst_ni,
    .stall_i    ( stall       ),
    .valid_i    ( valid_id    ),
    .pc_i       ( pc_id       ),
    .op_i       ( op_id       ),
    .opb_sel_i  ( opb_sel_id  ),
    .rs1_i      ( rs1_id      ),
    .rs2_i      ( rs2_id      ),
    .rd_i       ( rd_id       ),
    .imm_i      ( imm_id      ),
    .csr_addr_i ( csr_addr_id ),
    .we_i       ( we_id       ),
    .illegal_i  ( illegal_id  ),
    .wb_we_i    ( wb_we_ex    ),
    .wb_rd_i    ( wb_rd_ex    ),
    .wb_data_i  ( wb_data_ex  ),
    .valid_o    ( valid_is    ),
    .pc_o       ( pc_is       ),
    .op_o       ( op_is       ),
    .opa_o      ( opa_is      ),
    .opb_o      ( opb_is      ),
    .rd_o       ( rd_is       ),
    .csr_addr_o ( csr_addr_is ),
    .we_o       ( we_is       ),
    .illegal_o  ( illegal_is  )
  );

  ex_stage #(
    .Xlen ( Xlen )
  ) i_ex_stage (
    .stall_i     ( stall        ),
    .valid_i     ( valid_is     ),
    .pc_i        ( pc_is        ),
    .op_i        ( op_is        ),
    .opa_i       ( opa_is       ),
    .opb_i       ( opb_is       ),
    .rd_i        ( rd_is        ),
    .csr_addr_i  ( csr_addr_is  ),
    .we_i        ( we_is        ),
    .illegal_i   ( illegal_is   ),
    .csr_rdata_i ( csr_rdata    ),
    .csr_we_o    ( csr_we_ex    ),
    .csr_addr_o  ( csr_addr_ex  ),
    .csr_wdata_o ( csr_wdata_ex ),
    .retire_o    ( retire_ex    ),
    .wb_we_o     ( wb_we_ex     ),
    .wb_rd_o     ( wb_rd_ex     ),
    .wb_data_o   ( wb_data_ex   ),
    .valid_o     ( valid_ex     ),
    .pc_o        ( pc_ex        ),
    .illegal_o   ( illegal_ex   )
  );

  csr_regfile #(
    .Xlen ( Xlen )
  ) i_csr_regfile (
    .clk_i,
    .rst_ni,
    .csr_addr_i  ( csr_addr_ex  ),
    .csr_we_i    ( csr_we_ex    ),
    .csr_wdata_i ( csr_wdata_ex ),
    .retire_i    ( retire_ex    ),
    .csr_rdata_o ( csr_rdata    )
  );

  commit_stage #(
    .Xlen ( Xlen )
  ) i_commit_stage (
    .clk_i,
    .rst_ni,
    .valid_i     ( valid_ex     ),
    .pc_i        ( pc_ex        ),
    .rd_i        ( wb_rd_ex     ),
    .wdata_i     ( wb_data_ex   ),
    .we_i        ( wb_we_ex     ),
    .illegal_i   ( illegal_ex   ),
    .commit_ready_i,
    .stall_o     ( stall        ),
    .commit_valid_o,
    .commit_pc_o,
    .commit_rd_o,
    .commit_wdata_o,
    .commit_we_o,
    .commit_exception_o,
    .commit_cause_o
  );

endmodule

`default_nettype wire

// ==== test/rv_mini_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_mini_core_sva import riscv_pkg::*; #(
  parameter int unsigned Xlen = 32
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    fetch_valid_i,
  input logic [31:0]             fetch_instr_i,
  input logic [Xlen-1:0]         fetch_pc_i,
  input logic                    fetch_ready_o,
  input logic                    commit_ready_i,
  input logic                    commit_valid_o,
  input logic [Xlen-1:0]         commit_pc_o,
  input logic [RegAddrWidth-1:0] commit_rd_o,
  input logic [Xlen-1:0]         commit_wdata_o,
  input logic                    commit_we_o,
  input logic                    commit_exception_o,
  input logic [3:0]              commit_cause_o
);

  // a fetch request waits for ready
  fetch_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_o |=>
      fetch_valid_i && $stable(fetch_instr_i) && $stable(fetch_pc_i))
    else $error("fetch request dropped or changed before its transfer");

  commit_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !commit_ready_i |=>
      commit_valid_o && $stable(commit_pc_o) && $stable(commit_rd_o) &&
      $stable(commit_wdata_o) && $stable(commit_we_o) &&
      $stable(commit_exception_o) && $stable(commit_cause_o))
    else $error("commit trace changed while held off");

  // stalled pipeline takes no new instruction
  no_fetch_in_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !commit_ready_i |-> !fetch_ready_o)
    else $error("fetch ready raised during a stall");

endmodule

bind rv_mini_core rv_mini_core_sva #(
  .Xlen ( Xlen )
) i_rv_mini_core_sva (
  .clk_i,
  .rst_ni,
  .fetch_valid_i,
  .fetch_instr_i,
  .fetch_pc_i,
  .fetch_ready_o,
  .commit_ready_i,
  .commit_valid_o,
  .commit_pc_o,
  .commit_rd_o,
  .commit_wdata_o,
  .commit_we_o,
  .commit_exception_o,
  .commit_cause_o
);

`default_nettype wire

// ==== test/tb_rv_mini_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_mini_core import riscv_pkg::*; ();

  localparam int unsigned Xlen    = 32;
  localparam int          Timeout = 100;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    fetch_valid_i;
  logic [31:0]             fetch_instr_i;
  logic [Xlen-1:0]         fetch_pc_i;
  logic                    fetch_ready_o;
  logic                    commit_ready_i;
  logic                    commit_valid_o;
  logic [Xlen-1:0]         commit_pc_o;
  logic [RegAddrWidth-1:0] commit_rd_o;
  logic [Xlen-1:0]         commit_wdata_o;
  logic                    commit_we_o;
  logic                    commit_exception_o;
  logic [3:0]              commit_cause_o;

  // reference model state
  logic [Xlen-1:0] regs [32];
  logic [Xlen-1:0] mscratch_m;
  logic [Xlen-1:0] minstret_m;
  logic [Xlen-1:0] next_pc;
  logic [31:0]     op_lfsr = 32'h1838_2d3e;
  logic [31:0]     bp_lfsr = 32'h1838_2d3e;
  logic            bp_en = 1'b0;
  int              cycle = 0;
  int              n_pushed = 0;
  int              n_committed = 0;

  // expected commits, oldest first
  logic [Xlen-1:0]         exp_pc [$];
  logic [RegAddrWidth-1:0] exp_rd [$];
  logic                    exp_we [$];
  logic [Xlen-1:0]         exp_wdata [$];
  logic                    exp_exc [$];
  int                      exp_edge [$];

  rv_mini_core #(
    .Xlen ( Xlen )
  ) i_rv_mini_core (
    .clk_i,
    .rst_ni,
    .fetch_valid_i,
    .fetch_instr_i,
    .fetch_pc_i,
    .fetch_ready_o,
    .commit_ready_i,
    .commit_valid_o,
    .commit_pc_o,
    .commit_rd_o,
    .commit_wdata_o,
    .commit_we_o,
    .commit_exception_o,
    .commit_cause_o
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // ------------------------------------------------------------------------
  // random bits and reference ALU
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      op_lfsr = lfsr_step(op_lfsr);
      v = {v[30:0], op_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [Xlen-1:0] alu_ref(input logic [2:0] f3, input logic sub,
                                              input logic [Xlen-1:0] a,
                                              input logic [Xlen-1:0] b);
    case (f3)
      F3_ADD_SUB: return sub ? a - b : a + b;
      F3_SLL:     return a << b[$clog2(Xlen)-1:0];
      F3_SRL:     return a >> b[$clog2(Xlen)-1:0];
      F3_XOR:     return a ^ b;
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string what, input logic [Xlen-1:0] got,
                            input logic [Xlen-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_reg_idx(input string what, input logic [RegAddrWidth-1:0] got,
                               input logic [RegAddrWidth-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_exception(input logic got_exc, input logic [3:0] got_cause,
                                 input logic exp_exc);
    check_flag("commit exception", got_exc, exp_exc);
    if (exp_exc && got_cause !== CauseIllegalInstr) begin
      fail_run($sformatf("mismatch at %0d ns: cause is %0d, expected %0d", $time, got_cause,
                         CauseIllegalInstr));
    end
  endtask

  task automatic check_commit();
    logic [Xlen-1:0]         pc;
    logic [Xlen-1:0]         wdata;
    logic [RegAddrWidth-1:0] rd;
    logic                    we;
    logic                    exc;
    int                      fetch_edge;
    if (exp_pc.size() == 0) begin
      fail_run($sformatf("commit at %0d ns with no instruction outstanding", $time));
    end
    pc         = exp_pc.pop_front();
    rd         = exp_rd.pop_front();
    we         = exp_we.pop_front();
    wdata      = exp_wdata.pop_front();
    exc        = exp_exc.pop_front();
    fetch_edge = exp_edge.pop_front();
    check_data("commit pc", commit_pc_o, pc);
    check_reg_idx("commit rd", commit_rd_o, rd);
    check_flag("commit we", commit_we_o, we);
    check_exception(commit_exception_o, commit_cause_o, exc);
    if (we) begin
      check_data("commit wdata", commit_wdata_o, wdata);
    end
    // the commit transfer happens on the next edge
    if (fetch_edge >= 0 && cycle + 1 - fetch_edge != 3) begin
      fail_run($sformatf("mismatch at %0d ns: commit %0d edges after fetch, expected 3",
                         $time, cycle + 1 - fetch_edge));
    end
    n_committed++;
  endtask

  // trace consumer with optional back-pressure
  initial begin
    commit_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (bp_en) begin
        bp_lfsr = lfsr_step(bp_lfsr);
        commit_ready_i = bp_lfsr[0];
      end else begin
        commit_ready_i = 1'b1;
      end
      #1;
      if (rst_ni && commit_valid_o && commit_ready_i) begin
        check_commit();
      end
    end
  end

  // ------------------------------------------------------------------------
  // fetch side and instruction builders
  // ------------------------------------------------------------------------
  task automatic push_instr(input logic [31:0] instr, input logic [RegAddrWidth-1:0] rd,
                            input logic [Xlen-1:0] value, input logic illegal);
    int   waited;
    logic we;
    we            = !illegal && rd != '0;
    fetch_valid_i = 1'b1;
    fetch_instr_i = instr;
    fetch_pc_i    = next_pc;
    waited        = 0;
    #1;
    while (!fetch_ready_o) begin
      waited++;
      if (waited > Timeout) begin
        fail_run($sformatf("fetch handshake timed out at %0d ns", $time));
      end
      @(negedge clk_i);
      #1;
    end
    exp_pc.push_back(next_pc);
    exp_rd.push_back(rd);
    exp_we.push_back(we);
    exp_wdata.push_back(value);
    exp_exc.push_back(illegal);
    exp_edge.push_back(bp_en ? -1 : cycle + 1);
    if (we) begin
      regs[rd] = value;
    end
    if (!illegal) begin
      minstret_m = minstret_m + 1;
    end
    next_pc = next_pc + 4;
    n_pushed++;
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [RegAddrWidth-1:0] rd,
                        input logic [RegAddrWidth-1:0] rs1, input logic [11:0] imm);
    push_instr({imm, rs1, f3, rd, OPCODE_OP_IMM}, rd,
               alu_ref(f3, 1'b0, regs[rs1], Xlen'($signed(imm))), 1'b0);
  endtask

  task automatic op_reg(input logic sub, input logic [2:0] f3,
                        input logic [RegAddrWidth-1:0] rd, input logic [RegAddrWidth-1:0] rs1,
                        input logic [RegAddrWidth-1:0] rs2);
    push_instr({sub ? F7_SUB : F7_BASE, rs2, rs1, f3, rd, OPCODE_OP}, rd,
               alu_ref(f3, sub, regs[rs1], regs[rs2]), 1'b0);
  endtask

  task automatic lui(input logic [RegAddrWidth-1:0] rd, input logic [19:0] imm);
    push_instr({imm, rd, OPCODE_LUI}, rd, Xlen'($signed({imm, 12'b0})), 1'b0);
  endtask

  // csr ops return the old value, minstret ignores writes
  task automatic csr_op(input logic [2:0] f3, input logic [RegAddrWidth-1:0] rd,
                        input logic [RegAddrWidth-1:0] rs1, input csr_addr_e addr);
    logic [Xlen-1:0] old;
    old = (addr == CSR_MSCRATCH) ? mscratch_m : minstret_m;
    if (addr == CSR_MSCRATCH) begin
      mscratch_m = (f3 == F3_CSRRS) ? (old | regs[rs1]) : regs[rs1];
    end
    push_instr({addr, rs1, f3, rd, OPCODE_SYSTEM}, rd, old, 1'b0);
  endtask

  task automatic bad(input logic [31:0] instr);
    push_instr(instr, instr[11:7], '0, 1'b1);
  endtask

  task automatic random_op();
    logic [2:0]              kind;
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] rs1;
    logic [RegAddrWidth-1:0] rs2;
    logic [11:0]             imm;
    kind = 3'(take_bits(3));
    rd   = 5'(take_bits(5));
    rs1  = 5'(take_bits(5));
    rs2  = 5'(take_bits(5));
    imm  = 12'(take_bits(12));
    case (kind)
      3'd0:    op_imm(F3_ADD_SUB, rd, rs1, imm);
      3'd1:    op_imm(F3_AND, rd, rs1, imm);
      3'd2:    op_imm(F3_OR, rd, rs1, imm);
      3'd3:    op_imm(F3_XOR, rd, rs1, imm);
      3'd4:    lui(rd, {imm, rs2, rs1[2:0]});
      3'd5:    op_reg(imm[0], F3_ADD_SUB, rd, rs1, rs2);
      3'd6:    op_reg(1'b0, imm[0] ? F3_SLL : F3_SRL, rd, rs1, rs2);
      default: op_reg(1'b0, imm[1] ? F3_AND : (imm[0] ? F3_XOR : F3_OR), rd, rs1, rs2);
    endcase
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      #2;
      waited++;
      if (waited > Timeout) begin
        fail_run($sformatf("pipeline did not drain by %0d ns", $time));
      end
    end while (exp_pc.size() != 0);
    @(negedge clk_i);
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_imm_lui();
    // every register gets a known value first
    for (int r = 1; r < 32; r++) begin
      op_imm(F3_ADD_SUB, 5'(r), 5'd0, 12'(take_bits(12)));
    end
    lui(5'd1, 20'hABCDE);
    op_imm(F3_ADD_SUB, 5'd2, 5'd1, 12'h800);
    op_imm(F3_XOR, 5'd3, 5'd2, 12'hFFF);
    op_imm(F3_AND, 5'd4, 5'd1, 12'h7F0);
    op_imm(F3_OR, 5'd5, 5'd4, 12'h00F);
    repeat (20) random_op();
    drain();
  endtask

  task automatic test_forwarding();
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] prev;
    op_reg(1'b0, F3_ADD_SUB, 5'd5, 5'd6, 5'd7);
    op_reg(1'b1, F3_ADD_SUB, 5'd8, 5'd5, 5'd6);
    op_reg(1'b0, F3_XOR, 5'd9, 5'd8, 5'd5);
    op_reg(1'b0, F3_SLL, 5'd10, 5'd9, 5'd8);
    op_reg(1'b0, F3_SRL, 5'd11, 5'd10, 5'd9);
    op_imm(F3_ADD_SUB, 5'd11, 5'd11, 12'd1);
    op_reg(1'b0, F3_AND, 5'd12, 5'd11, 5'd11);
    prev = 5'd12;
    repeat (16) begin
      rd = 5'(take_bits(5));
      op_reg(1'(take_bits(1)), F3_ADD_SUB, rd, prev, rd);
      prev = rd;
    end
    drain();
  endtask

  task automatic test_x0();
    op_imm(F3_ADD_SUB, 5'd0, 5'd1, 12'h123);
    op_reg(1'b0, F3_OR, 5'd0, 5'd2, 5'd3);
    lui(5'd0, 20'h12345);
    op_reg(1'b0, F3_ADD_SUB, 5'd13, 5'd0, 5'd0);
    op_imm(F3_OR, 5'd14, 5'd0, 12'h000);
    drain();
  endtask

  task automatic test_csr();
    csr_op(F3_CSRRW, 5'd15, 5'd4, CSR_MSCRATCH);
    csr_op(F3_CSRRS, 5'd16, 5'd0, CSR_MSCRATCH);
    csr_op(F3_CSRRS, 5'd17, 5'd5, CSR_MSCRATCH);
    csr_op(F3_CSRRS, 5'd18, 5'd0, CSR_MSCRATCH);
    csr_op(F3_CSRRS, 5'd19, 5'd0, CSR_MINSTRET);
    csr_op(F3_CSRRW, 5'd20, 5'd6, CSR_MINSTRET);
    csr_op(F3_CSRRS, 5'd21, 5'd0, CSR_MINSTRET);
    // csr result feeds the next op directly
    op_reg(1'b1, F3_ADD_SUB, 5'd22, 5'd21, 5'd19);
    drain();
  endtask

  task automatic test_illegal();
    // lw x3, 0(x0)
    bad(32'h0000_2183);
    // sra, mul and slli
    bad({F7_SUB, 5'd2, 5'd1, F3_SRL, 5'd4, OPCODE_OP});
    bad({7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd5, OPCODE_OP});
    bad({12'd3, 5'd1, F3_SLL, 5'd6, OPCODE_OP_IMM});
    // mstatus, then csrrc on mscratch
    bad({12'h300, 5'd1, F3_CSRRW, 5'd7, OPCODE_SYSTEM});
    bad({12'h340, 5'd1, 3'b011, 5'd8, OPCODE_SYSTEM});
    op_reg(1'b0, F3_OR, 5'd23, 5'd3, 5'd4);
    op_reg(1'b0, F3_XOR, 5'd24, 5'd7, 5'd8);
    csr_op(F3_CSRRS, 5'd25, 5'd0, CSR_MINSTRET);
    csr_op(F3_CSRRS, 5'd26, 5'd0, CSR_MSCRATCH);
    drain();
  endtask

  task automatic test_backpressure();
    bp_en = 1'b1;
    repeat (40) random_op();
    csr_op(F3_CSRRS, 5'd27, 5'd0, CSR_MINSTRET);
    drain();
    bp_en = 1'b0;
    repeat (10) random_op();
    drain();
  endtask

  initial begin
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    next_pc       = 32'h0000_1000;
    mscratch_m    = '0;
    minstret_m    = '0;
    regs[0]       = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_imm_lui();
    test_forwarding();
    test_x0();
    test_csr();
    test_illegal();
    test_backpressure();
    // nothing may still be leaving the pipeline once it has drained
    if (n_committed == n_pushed && !commit_valid_o) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run($sformatf("pipeline not idle at the end, %0d commits for %0d fetches",
                         n_committed, n_pushed));
    end
  end

endmodule

`default_nettype wire

// ==== rv_mini_core.f ====
src/riscv_pkg.sv
src/core_pkg.sv
src/id_stage.sv
src/issue_stage.sv
src/ex_stage.sv
src/csr_regfile.sv
src/commit_stage.sv
src/rv_mini_core.sv
test/rv_mini_core_sva.sv
test/tb_rv_mini_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_mini_core -f rv_mini_core.f -o tb_rv_mini_core
./obj_dir/tb_rv_mini_core > sim.log 2>&1 || true
cat sim.log
if grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
